// File: hdl/memPkg.sv
`default_nettype none

package memPkg;

    // memory operation kinds from the execute stage
    typedef enum logic [3:0] {
        accNone,
        accLb,
        accLbu,
        accLh,
        accLhu,
        accLw,
        accLwl,
        accLwr,
        accSb,
        accSh,
        accSw,
        accSwl,
        accSwr
    } accessKindE;

    // bus control states
    typedef enum logic [1:0] {
        busIdle,
        busRequest,
        busWaitData,
        busDone
    } busStateE;

    typedef struct packed {
        accessKindE  kind;
        logic [31:0] addr;
        logic [31:0] storeData;
        logic [6:0]  destReg;
        logic        memToReg;
        logic        regWrite;
        logic [31:0] pc;
        logic [3:0]  excCode;
    } memReqS;

    typedef struct packed {
        logic        doAccess;
        logic        isWrite;
        logic [1:0]  size;
        logic [31:0] physAddr;
        logic [3:0]  byteEn;
        logic [31:0] wdata;
        logic [1:0]  lowAddr;
        accessKindE  kind;
        logic [6:0]  destReg;
        logic        memToReg;
        logic        regWrite;
        logic [31:0] pc;
        logic [3:0]  excCode;
    } busOpS;

    typedef struct packed {
        logic [6:0]  destReg;
        logic        regWrite;
        logic [3:0]  regByteWe;
        logic [31:0] data;
        logic [31:0] pc;
        logic [3:0]  excCode;
    } wbS;

    // uncached segment window
    localparam logic [31:0] kseg1Base = 32'hA000_0000;
    localparam logic [31:0] kseg1Limit = 32'hBFFF_FFFF;
    localparam int unsigned segmentMaskBits = 3;

    localparam logic [3:0] excNone = 4'd0;
    localparam logic [3:0] excInterrupt = 4'd7;

    // bus size codes
    localparam logic [1:0] sizeByte = 2'd0;
    localparam logic [1:0] sizeHalf = 2'd1;
    localparam logic [1:0] sizeWord = 2'd2;

endpackage

`default_nettype wire

// File: hdl/memAccessDecode.sv
`timescale 1ns/1ns
`default_nettype none

module memAccessDecode import memPkg::*; (
    input  logic   clk,
    input  logic   rst,
    input  logic   inValid,
    input  memReqS req,
    input  logic   accept,
    output busOpS  op
);

    logic [3:0]  prevExc;
    logic [1:0]  low;
    logic [4:0]  shiftUp;
    logic [4:0]  shiftDown;
    logic        isStore;
    logic        isWordClass;
    logic        inKseg;
    logic        blockStore;
    logic [31:0] segAddr;

    // exception of the last accepted item
    always_ff @(posedge clk) begin
        if (rst) begin
            prevExc <= excNone;
        end else if (accept) begin
            prevExc <= req.excCode;
        end
    end

    assign low = req.addr[1:0];
    assign shiftUp = {low, 3'b000};
    // 3 - low bytes, for swl
    assign shiftDown = {~low, 3'b000};

    assign isStore = req.kind inside {accSb, accSh, accSw, accSwl, accSwr};
    assign isWordClass = req.kind inside {accLw, accLwl, accLwr, accSw, accSwl, accSwr};

    assign inKseg = (req.addr >= kseg1Base) && (req.addr <= kseg1Limit);
    assign segAddr = {{segmentMaskBits{1'b0}}, req.addr[31-segmentMaskBits:0]};

    // store blocked by own exception, bad pc, or an earlier faulting item
    assign blockStore = (req.excCode != excNone) || (req.pc[1:0] != 2'b00) ||
                        ((prevExc != excNone) && (prevExc != excInterrupt));

    always_comb begin
        op.kind = req.kind;
        op.destReg = req.destReg;
        op.memToReg = req.memToReg;
        op.regWrite = req.regWrite;
        op.pc = req.pc;
        op.excCode = req.excCode;
        op.isWrite = isStore;
        op.lowAddr = low;
        op.doAccess = inValid && (req.kind != accNone) && !(isStore && blockStore);

        // non-memory results are not addresses, leave them alone
        if (req.kind == accNone) begin
            op.physAddr = req.addr;
        end else begin
            op.physAddr = inKseg ? segAddr : req.addr;
            if (isWordClass) begin
                op.physAddr[1:0] = 2'b00;
            end
        end

        op.size = sizeWord;
        op.byteEn = 4'b0000;
        op.wdata = '0;
        case (req.kind)
            accLb, accLbu, accSb: begin
                op.size = sizeByte;
                op.byteEn = 4'b0001 << low;
                op.wdata = {24'b0, req.storeData[7:0]} << shiftUp;
            end
            accLh, accLhu, accSh: begin
                op.size = sizeHalf;
                // odd half offsets get no lanes
                if (!low[0]) begin
                    op.byteEn = 4'b0011 << low;
                    op.wdata = {16'b0, req.storeData[15:0]} << shiftUp;
                end
            end
            accSwl: begin
                // upper register bytes into the low lanes
                op.byteEn = 4'b1111 >> ~low;
                op.wdata = req.storeData >> shiftDown;
            end
            accSwr: begin
                op.byteEn = 4'b1111 << low;
                op.wdata = req.storeData << shiftUp;
            end
            default: begin
                op.byteEn = 4'b1111;
                op.wdata = req.storeData;
            end
        endcase
    end

endmodule

`default_nettype wire

// File: hdl/memBusCtrl.sv
`timescale 1ns/1ns
`default_nettype none

module memBusCtrl import memPkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic        inValid,
    input  busOpS       op,
    output logic        accept,
    output busOpS       heldOp,
    output logic [31:0] rdata,
    output logic        opDone,
    output logic        stall,
    output logic        memReq,
    output logic        memWr,
    output logic [1:0]  memSize,
    output logic [31:0] memAddr,
    output logic [31:0] memWdata,
    output logic [3:0]  memByteEn,
    input  logic        memAddrOk,
    input  logic        memDataOk,
    input  logic [31:0] memRdata
);

    busStateE state;
    busStateE stateNext;
    logic     retire;

    // the finished item is still presented for one cycle, so it is not taken again
    assign accept = inValid && (state == busIdle) && !retire;
    assign stall = (state != busIdle) || (inValid && !retire);
    assign opDone = (state == busDone);

    always_comb begin
        stateNext = state;
        case (state)
            busIdle: begin
                if (accept) begin
                    stateNext = op.doAccess ? busRequest : busDone;
                end
            end
            busRequest: begin
                if (memAddrOk) begin
                    stateNext = busWaitData;
                end
            end
            busWaitData: begin
                if (memDataOk) begin
                    stateNext = busDone;
                end
            end
            default: begin
                stateNext = busIdle;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= busIdle;
            retire <= 1'b0;
        end else begin
            state <= stateNext;
            retire <= (state == busDone);
        end
    end

    // item and read word held for the whole access
    always_ff @(posedge clk) begin
        if (accept) begin
            heldOp <= op;
        end
        if ((state == busWaitData) && memDataOk) begin
            rdata <= memRdata;
        end
    end

    assign memReq = (state == busRequest);
    assign memWr = memReq && heldOp.isWrite;
    assign memSize = heldOp.size;
    assign memAddr = heldOp.physAddr;
    assign memWdata = heldOp.wdata;
    assign memByteEn = heldOp.byteEn;

endmodule

`default_nettype wire

// File: hdl/loadAlign.sv
`timescale 1ns/1ns
`default_nettype none

module loadAlign import memPkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic        opDone,
    input  busOpS       heldOp,
    input  logic [31:0] rdata,
    output wbS          wb,
    output logic        wbValid
);

    logic [31:0] loadData;
    logic [31:0] wbData;
    logic [3:0]  byteWe;
    logic [7:0]  laneByte;
    logic [15:0] laneHalf;
    logic [4:0]  shiftUp;
    logic [4:0]  shiftDown;

    assign shiftDown = {heldOp.lowAddr, 3'b000};
    assign shiftUp = {~heldOp.lowAddr, 3'b000};

    // addressed lane of the read word
    assign laneByte = rdata[shiftDown +: 8];
    assign laneHalf = rdata[{heldOp.lowAddr[1], 4'b0000} +: 16];

    always_comb begin
        loadData = rdata;
        byteWe = 4'b1111;
        case (heldOp.kind)
            accLb: begin
                loadData = {{24{laneByte[7]}}, laneByte};
            end
            accLbu: begin
                loadData = {24'b0, laneByte};
            end
            accLh: begin
                loadData = {{16{laneHalf[15]}}, laneHalf};
            end
            accLhu: begin
                loadData = {16'b0, laneHalf};
            end
            accLwl: begin
                // low memory bytes go to the top of the register
                loadData = rdata << shiftUp;
                byteWe = 4'b1111 << ~heldOp.lowAddr;
            end
            accLwr: begin
                loadData = rdata >> shiftDown;
                byteWe = 4'b1111 >> heldOp.lowAddr;
            end
            default: begin
                loadData = rdata;
            end
        endcase
    end

    // non-load items write back the address word
    assign wbData = heldOp.memToReg ? loadData : heldOp.physAddr;

    always_ff @(posedge clk) begin
        if (opDone) begin
            wb.destReg <= heldOp.destReg;
            wb.regWrite <= heldOp.regWrite;
            wb.regByteWe <= byteWe;
            wb.data <= wbData;
            wb.pc <= heldOp.pc;
            wb.excCode <= heldOp.excCode;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wbValid <= 1'b0;
        end else begin
            wbValid <= opDone;
        end
    end

endmodule

`default_nettype wire

// File: hdl/memStage.sv
`timescale 1ns/1ns
`default_nettype none

module memStage import memPkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic        inValid,
    input  memReqS      req,
    output logic        stall,
    output wbS          wb,
    output logic        wbValid,
    output logic        memReq,
    output logic        memWr,
    output logic [1:0]  memSize,
    output logic [31:0] memAddr,
    output logic [31:0] memWdata,
    output logic [3:0]  memByteEn,
    input  logic        memAddrOk,
    input  logic        memDataOk,
    input  logic [31:0] memRdata
);

    busOpS       op;
    busOpS       heldOp;
    logic        accept;
    logic [31:0] rdata;
    logic        opDone;

    memAccessDecode u_memAccessDecode (
        .clk     (clk),
        .rst     (rst),
        .inValid (inValid),
        .req     (req),
        .accept  (accept),
        .op      (op)
    );

    memBusCtrl u_memBusCtrl (
        .clk       (clk),
        .rst       (rst),
        .inValid   (inValid),
        .op        (op),
        .accept    (accept),
        .heldOp    (heldOp),
        .rdata     (rdata),
        .opDone    (opDone),
        .stall     (stall),
        .memReq    (memReq),
        .memWr     (memWr),
        .memSize   (memSize),
        .memAddr   (memAddr),
        .memWdata  (memWdata),
        .memByteEn (memByteEn),
        .memAddrOk (memAddrOk),
        .memDataOk (memDataOk),
        .memRdata  (memRdata)
    );

    loadAlign u_loadAlign (
        .clk     (clk),
        .rst     (rst),
        .opDone  (opDone),
        .heldOp  (heldOp),
        .rdata   (rdata),
        .wb      (wb),
        .wbValid (wbValid)
    );

endmodule

`default_nettype wire

// File: dv/memStage_checker.sv
`timescale 1ns/1ns
`default_nettype none

module memStage_checker (
    input wire        clk,
    input wire        rst,
    input wire        memReq,
    input wire        memWr,
    input wire [31:0] memAddr,
    input wire [31:0] memWdata,
    input wire [3:0]  memByteEn,
    input wire        memAddrOk,
    input wire        stall,
    input wire        wbValid
);

    // request and its fields hold until the slave takes the address
    reqHeld: assert property (@(posedge clk) disable iff (rst)
        (memReq && !memAddrOk) |=> (memReq && $stable(memAddr) && $stable(memWdata)
            && $stable(memByteEn) && $stable(memWr)))
        else $error("memReq dropped or changed before memAddrOk");

    stallDuringReq: assert property (@(posedge clk) disable iff (rst) memReq |-> stall)
        else $error("stall low while memReq high");

    // one writeback per item
    singleWb: assert property (@(posedge clk) disable iff (rst) wbValid |=> !wbValid)
        else $error("wbValid high in two consecutive cycles");

endmodule

bind memStage memStage_checker u_memStageChecker (.*);

`default_nettype wire

// File: dv/memStageTb.sv
`timescale 1ns/1ns
`default_nettype none

module memStageTb import memPkg::*; ();

    localparam int maxOpCycles = 16;
    localparam int numOps = 64;
    localparam int watchdogNs = numOps * maxOpCycles * 10 + 2000;

    logic clk;
    logic rst;
    logic inValid;
    memReqS req;
    logic stall;
    wbS wb;
    logic wbValid;
    logic memReq;
    logic memWr;
    logic [1:0] memSize;
    logic [31:0] memAddr;
    logic [31:0] memWdata;
    logic [3:0] memByteEn;
    logic memAddrOk;
    logic memDataOk;
    logic [31:0] memRdata;

    logic [31:0] lfsr;
    logic [31:0] mem [256];
    int phase;
    int addrWait;
    int dataWait;
    int reqCount;
    logic [31:0] lastAddr;
    logic [31:0] lastWdata;
    logic [3:0] lastByteEn;
    logic lastWr;
    logic [1:0] lastSize;
    int lastCycles;
    int valErrs;
    int otherErrs;

    memStage u_memStage (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial begin
        #(watchdogNs);
        $display("watchdog expired, the run did not finish in time");
        $display("Test FAILED");
        $finish;
    end

    // galois lfsr, one step per bit
    function automatic logic [31:0] randBits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r = {r[30:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
        end
        return r;
    endfunction

    function automatic logic [31:0] laneMask(input logic [3:0] en);
        logic [31:0] m;
        for (int i = 0; i < 4; i++) begin
            m[i*8 +: 8] = {8{en[i]}};
        end
        return m;
    endfunction

    function automatic logic [31:0] physOf(input accessKindE k, input logic [31:0] a);
        logic [31:0] r;
        r = a;
        if (a >= kseg1Base && a <= kseg1Limit) begin
            for (int i = 0; i < segmentMaskBits; i++) begin
                r[31-i] = 1'b0;
            end
        end
        if (k inside {accLw, accLwl, accLwr, accSw, accSwl, accSwr}) begin
            r[1:0] = 2'b00;
        end
        return r;
    endfunction

    // bus size code for each access kind
    function automatic logic [1:0] sizeOfKind(input accessKindE k);
        logic [1:0] s;
        s = sizeWord;
        if (k inside {accLb, accLbu, accSb}) begin
            s = sizeByte;
        end else if (k inside {accLh, accLhu, accSh}) begin
            s = sizeHalf;
        end
        return s;
    endfunction

    // slave with lfsr delays, driven on the falling edge
    always @(negedge clk) begin
        memAddrOk = 1'b0;
        memDataOk = 1'b0;
        if (rst) begin
            phase = 0;
        end else if (phase == 0) begin
            if (memReq) begin
                if (addrWait == 0) begin
                    memAddrOk = 1'b1;
                    lastAddr = memAddr;
                    lastWdata = memWdata;
                    lastByteEn = memByteEn;
                    lastWr = memWr;
                    lastSize = memSize;
                    reqCount++;
                    dataWait = int'(randBits(2)) % 3;
                    phase = 1;
                end else begin
                    addrWait--;
                end
            end
        end else if (dataWait == 0) begin
            memDataOk = 1'b1;
            if (lastWr) begin
                mem[lastAddr[9:2]] = (mem[lastAddr[9:2]] & ~laneMask(lastByteEn)) |
                                     (lastWdata & laneMask(lastByteEn));
            end else begin
                memRdata = mem[lastAddr[9:2]];
            end
            addrWait = int'(randBits(2));
            phase = 0;
        end else begin
            dataWait--;
        end
    end

    // one item, held until the edge after wbValid
    task automatic runOp(input accessKindE kind, input logic [31:0] addr,
                         input logic [31:0] data, input logic [31:0] pc,
                         input logic [3:0] exc);
        int cycles;
        req.kind = kind;
        req.addr = addr;
        req.storeData = data;
        req.destReg = 7'(randBits(7));
        req.memToReg = kind inside {accLb, accLbu, accLh, accLhu, accLw, accLwl, accLwr};
        req.regWrite = req.memToReg || (kind == accNone);
        req.pc = pc;
        req.excCode = exc;
        inValid = 1'b1;
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
            if (!wbValid && !stall) begin
                otherErrs++;
                $display("stall went low before writeback at cycle %0d", cycles);
            end
        end while (!wbValid && cycles < maxOpCycles);
        if (!wbValid) begin
            otherErrs++;
            $display("no writeback within %0d cycles", maxOpCycles);
        end else begin
            if (wb.pc !== pc) begin
                valErrs++;
                $display("ERR wb.pc got %h exp %h", wb.pc, pc);
            end
            if (wb.excCode !== exc) begin
                valErrs++;
                $display("ERR wb.excCode got %h exp %h", wb.excCode, exc);
            end
            if (wb.destReg !== req.destReg) begin
                valErrs++;
                $display("ERR wb.destReg got %h exp %h", wb.destReg, req.destReg);
            end
            if (wb.regWrite !== req.regWrite) begin
                valErrs++;
                $display("ERR wb.regWrite got %h exp %h", wb.regWrite, req.regWrite);
            end
        end
        lastCycles = cycles;
        // stall was high at the opDone edge, so the item stays one more cycle
        @(negedge clk);
        inValid = 1'b0;
    endtask

    task automatic checkStore(input accessKindE kind, input logic [31:0] addr);
        logic [31:0] data;
        logic [31:0] old;
        logic [31:0] wd;
        logic [31:0] m;
        logic [3:0] en;
        int off;
        int startReqs;
        data = randBits(32);
        off = int'(addr[1:0]);
        old = mem[addr[9:2]];
        en = '0;
        wd = '0;
        for (int i = 0; i < 4; i++) begin
            if (kind == accSb && i == off) begin
                en[i] = 1'b1;
                wd[i*8 +: 8] = data[7:0];
            end else if (kind == accSh && (i == off || i == off + 1)) begin
                en[i] = 1'b1;
                wd[i*8 +: 8] = data[(i-off)*8 +: 8];
            end else if (kind == accSw) begin
                en[i] = 1'b1;
                wd[i*8 +: 8] = data[i*8 +: 8];
            end else if (kind == accSwl && i <= off) begin
                en[i] = 1'b1;
                wd[i*8 +: 8] = data[(3-off+i)*8 +: 8];
            end else if (kind == accSwr && i >= off) begin
                en[i] = 1'b1;
                wd[i*8 +: 8] = data[(i-off)*8 +: 8];
            end
        end
        m = laneMask(en);
        startReqs = reqCount;
        runOp(kind, addr, data, 32'h0040_0000, excNone);
        if (reqCount != startReqs + 1) begin
            otherErrs++;
            $display("store %s made no bus request", kind.name());
        end
        if (lastByteEn !== en || lastWr !== 1'b1) begin
            valErrs++;
            $display("ERR memByteEn got %h exp %h", lastByteEn, en);
        end
        if (lastSize !== sizeOfKind(kind)) begin
            valErrs++;
            $display("ERR memSize got %h exp %h", lastSize, sizeOfKind(kind));
        end
        if ((lastWdata & m) !== (wd & m)) begin
            valErrs++;
            $display("ERR memWdata got %h exp %h", lastWdata & m, wd & m);
        end
        if (lastAddr !== physOf(kind, addr)) begin
            valErrs++;
            $display("ERR memAddr got %h exp %h", lastAddr, physOf(kind, addr));
        end
        if (mem[addr[9:2]] !== ((old & ~m) | (wd & m))) begin
            valErrs++;
            $display("ERR mem got %h exp %h", mem[addr[9:2]], (old & ~m) | (wd & m));
        end
    endtask

    task automatic checkLoad(input accessKindE kind, input logic [31:0] addr);
        logic [31:0] word;
        logic [31:0] exp;
        logic [3:0] we;
        int off;
        word = mem[addr[9:2]];
        off = int'(addr[1:0]);
        exp = '0;
        we = 4'hF;
        case (kind)
            accLb: exp = {{24{word[off*8+7]}}, word[off*8 +: 8]};
            accLbu: exp = {24'b0, word[off*8 +: 8]};
            accLh: exp = {{16{word[off*8+15]}}, word[off*8 +: 16]};
            accLhu: exp = {16'b0, word[off*8 +: 16]};
            accLwl: begin
                for (int j = 0; j < 4; j++) begin
                    we[j] = (j >= 3 - off);
                    if (j >= 3 - off) exp[j*8 +: 8] = word[(j-3+off)*8 +: 8];
                end
            end
            accLwr: begin
                for (int j = 0; j < 4; j++) begin
                    we[j] = (j <= 3 - off);
                    if (j <= 3 - off) exp[j*8 +: 8] = word[(j+off)*8 +: 8];
                end
            end
            default: exp = word;
        endcase
        runOp(kind, addr, 32'h0, 32'h0040_0010, excNone);
        if (wb.regByteWe !== we) begin
            valErrs++;
            $display("ERR regByteWe got %h exp %h", wb.regByteWe, we);
        end
        if ((wb.data & laneMask(we)) !== (exp & laneMask(we))) begin
            valErrs++;
            $display("ERR wb.data got %h exp %h", wb.data & laneMask(we), exp & laneMask(we));
        end
        if (lastAddr !== physOf(kind, addr) || lastWr !== 1'b0) begin
            valErrs++;
            $display("ERR memAddr got %h exp %h", lastAddr, physOf(kind, addr));
        end
        if (lastSize !== sizeOfKind(kind)) begin
            valErrs++;
            $display("ERR memSize got %h exp %h", lastSize, sizeOfKind(kind));
        end
    endtask

    task automatic checkGate(input logic [31:0] pc, input logic [3:0] exc,
                             input logic blocked);
        logic [31:0] old;
        int startReqs;
        old = mem[8'h40];
        startReqs = reqCount;
        runOp(accSw, 32'h0000_0100, randBits(32), pc, exc);
        if (blocked && (reqCount != startReqs || mem[8'h40] !== old)) begin
            otherErrs++;
            $display("suppressed store reached the bus, exc %h pc %h", exc, pc);
        end
        if (blocked && lastCycles != 2) begin
            valErrs++;
            $display("ERR wbValid latency got %h exp %h", lastCycles, 2);
        end
        if (!blocked && reqCount != startReqs + 1) begin
            otherErrs++;
            $display("allowed store made no bus request, exc %h", exc);
        end
    endtask

    task automatic checkNonMem(input logic [31:0] value);
        int startReqs;
        startReqs = reqCount;
        runOp(accNone, value, 32'h0, 32'h0040_0020, excNone);
        if (lastCycles != 2 || reqCount != startReqs) begin
            otherErrs++;
            $display("non-memory op took %0d cycles or used the bus", lastCycles);
        end
        if (wb.data !== value || wb.regByteWe !== 4'hF) begin
            valErrs++;
            $display("ERR wb.data got %h exp %h", wb.data, value);
        end
    endtask

    initial begin
        rst = 1'b1;
        inValid = 1'b0;
        req = '0;
        memAddrOk = 1'b0;
        memDataOk = 1'b0;
        memRdata = '0;
        lfsr = 32'd92905;
        phase = 0;
        addrWait = 0;
        dataWait = 0;
        reqCount = 0;
        valErrs = 0;
        otherErrs = 0;
        for (int i = 0; i < 256; i++) begin
            mem[i] = 32'(i + 1) * 32'h9E37_79B9;
        end
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        @(negedge clk);

        for (int o = 0; o < 4; o++) checkStore(accSb, 32'h0000_0080 + o);
        checkStore(accSh, 32'h0000_0084);
        checkStore(accSh, 32'h0000_0086);
        checkStore(accSw, 32'h0000_0088);
        for (int o = 0; o < 4; o++) begin
            checkStore(accSwl, 32'h0000_0090 + 4 * o + o);
            checkStore(accSwr, 32'h0000_00B0 + 4 * o + o);
        end
        // loads through the kseg1 window
        for (int o = 0; o < 4; o++) begin
            checkLoad(accLb, 32'hA000_0200 + o);
            checkLoad(accLbu, 32'hA000_0204 + o);
            checkLoad(accLwl, 32'hA000_0208 + o);
            checkLoad(accLwr, 32'hA000_020C + o);
        end
        for (int o = 0; o < 4; o += 2) begin
            checkLoad(accLh, 32'hA000_0210 + o);
            checkLoad(accLhu, 32'hA000_0214 + o);
        end
        checkLoad(accLw, 32'hBFC0_0123);
        checkStore(accSw, 32'hA000_0343);

        checkGate(32'h0040_0000, 4'd4, 1'b1);
        checkGate(32'h0040_0000, excNone, 1'b1);
        checkGate(32'h0040_0000, excNone, 1'b0);
        checkGate(32'h0040_0002, excNone, 1'b1);
        checkGate(32'h0040_0000, excInterrupt, 1'b1);
        checkGate(32'h0040_0000, excNone, 1'b0);

        checkNonMem(32'h1234_5678);
        checkNonMem(32'hA000_0001);
        for (int i = 0; i < 8; i++) checkLoad(accLw, 32'h0000_0300 + 4 * i);

        $display("value errors: %0d, other errors: %0d", valErrs, otherErrs);
        if (valErrs == 0 && otherErrs == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: project.f
hdl/memPkg.sv
hdl/memAccessDecode.sv
hdl/memBusCtrl.sv
hdl/loadAlign.sv
hdl/memStage.sv
dv/memStage_checker.sv
dv/memStageTb.sv

// File: run.sh
#!/bin/sh
# build and run the memStage testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module memStageTb -Mdir obj_dir -o simv -f project.f
if [ $? -ne 0 ]; then
    echo "compile failed"
    exit 1
fi

./obj_dir/simv > sim.log 2>&1
status=$?
cat sim.log

if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi
if grep -q "Test FAILED" sim.log; then
    exit 1
fi
if ! grep -q "Test OK" sim.log; then
    echo "no pass line in sim.log"
    exit 1
fi
exit 0
